/* compile.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_sequencer.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/reg_writeback.sv
rtl/tiny_core.sv
tests/tb_mem_model.sv
tests/tb_tiny_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_tiny_core
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tests/tb_tiny_core.sv */
`default_nettype none
`include "core_params.svh"

module tb_tiny_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    logic clk;
    logic nreset;
    logic stall_en;
    word_t address;
    word_t data_in;
    word_t data_out;
    logic nrd;
    logic [3:0] nwr;
    logic ready;
    logic hlt;
    logic error;

    instr_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int store_idx;
    int cycles;
    int run_limit;
    logic prev_valid;
    logic prev_ready;
    logic prev_nrd;
    logic [3:0] prev_nwr;

    tiny_core tiny_core_inst (
        .clk(clk),
        .nreset(nreset),
        .address(address),
        .data_in(data_in),
        .data_out(data_out),
        .nrd(nrd),
        .nwr(nwr),
        .ready(ready),
        .hlt(hlt),
        .error(error)
    );

    tb_mem_model mem_model_inst (
        .clk(clk),
        .stall_en(stall_en),
        .address(address),
        .wdata(data_out),
        .nwr(nwr),
        .rdata(data_in),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_strobe(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic instr_t r_word(int f7, int f3, int rd, int rs1, int rs2);
        instr_t w;
        w.r.opcode = OPC_OP;
        w.r.funct7 = f7[6:0];
        w.r.funct3 = f3[2:0];
        w.r.rd = rd[4:0];
        w.r.rs1 = rs1[4:0];
        w.r.rs2 = rs2[4:0];
        return w;
    endfunction

    function automatic instr_t i_word(opcode_t op, int f3, int rd, int rs1, int imm);
        instr_t w;
        w.i.opcode = op;
        w.i.funct3 = f3[2:0];
        w.i.rd = rd[4:0];
        w.i.rs1 = rs1[4:0];
        w.i.imm = imm[11:0];
        return w;
    endfunction

    function automatic instr_t s_word(int rs2, int rs1, int imm);
        instr_t w;
        w.s.opcode = OPC_STORE;
        w.s.funct3 = 3'b010;
        w.s.rs1 = rs1[4:0];
        w.s.rs2 = rs2[4:0];
        w.s.imm_hi = imm[11:5];
        w.s.imm_lo = imm[4:0];
        return w;
    endfunction

    function automatic instr_t b_word(int f3, int rs1, int rs2, int off);
        instr_t w;
        w.b.opcode = OPC_BRANCH;
        w.b.funct3 = f3[2:0];
        w.b.rs1 = rs1[4:0];
        w.b.rs2 = rs2[4:0];
        w.b.imm12 = off[12];
        w.b.imm11 = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1 = off[4:1];
        return w;
    endfunction

    function automatic instr_t u_word(opcode_t op, int rd, int imm20);
        instr_t w;
        w.u.opcode = op;
        w.u.rd = rd[4:0];
        w.u.imm = imm20[19:0];
        return w;
    endfunction

    function automatic instr_t j_word(int rd, int off);
        instr_t w;
        w.j.opcode = OPC_JAL;
        w.j.rd = rd[4:0];
        w.j.imm20 = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11 = off[11];
        w.j.imm10_1 = off[10:1];
        return w;
    endfunction

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_main_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        prog.push_back(i_word(OPC_OP_IMM, 0, 1, 0, 'h123));     // 00
        prog.push_back(i_word(OPC_OP_IMM, 0, 2, 0, -5));
        prog.push_back(r_word(0, 0, 3, 1, 2));                  // add
        prog.push_back(s_word(3, 0, 'h200));
        prog.push_back(r_word('h20, 0, 4, 1, 2));               // 10 sub
        prog.push_back(s_word(4, 0, 'h204));
        prog.push_back(i_word(OPC_OP_IMM, 1, 5, 1, 4));         // slli
        prog.push_back(s_word(5, 0, 'h208));
        prog.push_back(i_word(OPC_OP_IMM, 5, 6, 2, 'h401));     // 20 srai
        prog.push_back(s_word(6, 0, 'h20C));
        prog.push_back(r_word(0, 5, 7, 2, 5));                  // srl by x5
        prog.push_back(s_word(7, 0, 'h210));
        prog.push_back(r_word(0, 2, 8, 2, 1));                  // 30 slt
        prog.push_back(r_word(0, 3, 9, 2, 1));                  // sltu
        prog.push_back(i_word(OPC_OP_IMM, 1, 8, 8, 1));
        prog.push_back(r_word(0, 6, 8, 8, 9));
        prog.push_back(s_word(8, 0, 'h214));                    // 40
        prog.push_back(r_word(0, 4, 10, 1, 2));                 // xor
        prog.push_back(i_word(OPC_OP_IMM, 7, 11, 10, 'h7F0));   // andi
        prog.push_back(s_word(11, 0, 'h218));
        prog.push_back(u_word(OPC_LUI, 12, 'hABCDE));           // 50
        prog.push_back(s_word(12, 0, 'h21C));
        prog.push_back(u_word(OPC_AUIPC, 13, 1));               // at 0x58
        prog.push_back(s_word(13, 0, 'h220));
        prog.push_back(b_word(0, 1, 1, 8));                     // 60 beq taken
        prog.push_back(s_word(1, 0, 'h3F0));
        prog.push_back(b_word(1, 1, 1, 8));                     // bne not taken
        prog.push_back(b_word(4, 2, 1, 8));                     // blt taken
        prog.push_back(s_word(2, 0, 'h3F0));
        prog.push_back(b_word(5, 2, 1, 8));                     // 74 bge not taken
        prog.push_back(b_word(6, 2, 1, 8));                     // bltu not taken
        prog.push_back(b_word(7, 2, 1, 8));                     // bgeu taken
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(j_word(14, 8));                          // 84 jal
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(s_word(14, 0, 'h224));
        prog.push_back(i_word(OPC_OP_IMM, 0, 15, 0, 'hA5));
        prog.push_back(i_word(OPC_JALR, 0, 16, 15, -8));        // 94, lands on 0x9C
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(s_word(16, 0, 'h228));
        prog.push_back(b_word(0, 1, 2, 8));                     // A0 beq not taken
        prog.push_back(b_word(1, 1, 2, 8));                     // bne taken
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(b_word(4, 1, 2, 8));                     // AC blt not taken
        prog.push_back(b_word(5, 1, 2, 8));                     // bge taken
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(b_word(6, 1, 2, 8));                     // B8 bltu taken
        prog.push_back(s_word(0, 0, 'h3F0));
        prog.push_back(b_word(7, 1, 2, 8));                     // bgeu not taken
        prog.push_back(s_word(10, 0, 'h22C));                   // C4
        prog.push_back(i_word(OPC_LOAD, 2, 17, 0, 'h22C));
        prog.push_back(s_word(17, 0, 'h230));
        prog.push_back(i_word(OPC_OP_IMM, 0, 0, 0, 'h55));      // write to x0
        prog.push_back(s_word(0, 0, 'h234));                    // D4
        prog.push_back(instr_t'(32'h0010_0073));                // ebreak
        expect_store('h200, 32'h123 + 32'hFFFF_FFFB);
        expect_store('h204, 32'h123 - 32'hFFFF_FFFB);
        expect_store('h208, 32'h123 << 4);
        expect_store('h20C, 32'hFFFF_FFFD);                     // -5 >>> 1
        expect_store('h210, 32'hFFFF_FFFB >> (32'h1230 & 31));
        expect_store('h214, (32'd1 << 1) | 32'd0);
        expect_store('h218, (32'h123 ^ 32'hFFFF_FFFB) & 32'h7F0);
        expect_store('h21C, 32'hABCD_E000);
        expect_store('h220, 32'h58 + 32'h1000);
        expect_store('h224, 32'h84 + 4);
        expect_store('h228, 32'h94 + 4);
        expect_store('h22C, 32'h123 ^ 32'hFFFF_FFFB);
        expect_store('h230, 32'h123 ^ 32'hFFFF_FFFB);
        expect_store('h234, 32'h0);
    endtask

    task automatic build_illegal_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        prog.push_back(i_word(OPC_OP_IMM, 0, 1, 0, 7));
        prog.push_back(s_word(1, 0, 'h200));
        prog.push_back(instr_t'(32'hFFFF_FFFF));
        prog.push_back(s_word(1, 0, 'h204));                    // never reached
        expect_store('h200, 32'd7);
    endtask

    // store events in order, sampled mid-cycle
    always @(negedge clk) begin
        if (!nreset) begin
            store_idx = 0;
        end else if (ready && nwr != 4'b1111) begin
            if (store_idx >= exp_addr.size()) begin
                $display("unexpected store to %h at %0t", address, $time);
                abort_run();
            end
            check_word("address", exp_addr[store_idx], address);
            check_word("data_out", exp_data[store_idx], data_out);
            check_strobe("nwr", 4'b0000, nwr);
            store_idx++;
        end
    end

    always @(negedge clk) begin
        if (prev_valid && !prev_ready) begin
            check_flag("nrd", prev_nrd, nrd);                   // frozen by the stall
            check_strobe("nwr", prev_nwr, nwr);
        end
        prev_valid = nreset;
        prev_ready = ready;
        prev_nrd = nrd;
        prev_nwr = nwr;
    end

    always @(posedge clk) begin
        if (!nreset) begin
            cycles = 0;
        end else begin
            cycles++;
            if (cycles > run_limit) begin
                $display("timeout: core did not halt within %0d cycles", run_limit);
                abort_run();
            end
        end
    end

    task automatic run_program(input logic stalls, input logic exp_error);
        @(posedge clk);
        #1;
        nreset = 1'b0;
        stall_en = stalls;
        mem_model_inst.fill_memory();
        foreach (prog[k]) begin
            mem_model_inst.load_word(k, prog[k]);
        end
        run_limit = prog.size() * `CORE_NSTAGES * 4 + 200;
        repeat (16) @(posedge clk);
        #1 nreset = 1'b1;
        while (hlt !== 1'b1) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        if (store_idx != exp_addr.size()) begin
            $display("only %0d of %0d stores seen", store_idx, exp_addr.size());
            abort_run();
        end
        check_flag("hlt", 1'b1, hlt);
        check_flag("error", exp_error, error);
    endtask

    initial begin
        nreset = 1'b0;
        stall_en = 1'b0;
        run_limit = 1000;
        prev_valid = 1'b0;
        prev_ready = 1'b1;
        prev_nrd = 1'b1;
        prev_nwr = 4'b1111;
        build_main_program();
        run_program(1'b0, 1'b0);
        run_program(1'b1, 1'b0);
        build_illegal_program();
        run_program(1'b0, 1'b1);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
`default_nettype none
`include "core_params.svh"

module tb_mem_model (
    input wire clk,
    input wire stall_en,
    input wire core_pkg::word_t address,
    input wire core_pkg::word_t wdata,
    input wire [3:0] nwr,
    output core_pkg::word_t rdata,
    output logic ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int DEPTH = 256;

    word_t mem [DEPTH];
    logic [31:0] rnd_state = 32'd81498;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_memory();
        for (int k = 0; k < DEPTH; k++) begin
            mem[k] = 32'hDEAD_0000 | word_t'(k * 4); // pattern tracks the byte address
        end
    endtask

    task automatic load_word(input int index, input instr_t w);
        mem[index] = w.raw;
    endtask

    assign rdata = mem[address[9:2]]; // valid whenever ready is high

    initial begin
        ready = 1'b1;
    end

    // ready changes just after the edge, low on about a quarter of cycles
    always @(posedge clk) begin
        rnd_state = xorshift32(rnd_state);
        #1 ready = stall_en ? (rnd_state[1:0] != 2'b00) : 1'b1;
    end

    always @(negedge clk) begin
        if (ready) begin
            for (int k = 0; k < 4; k++) begin
                if (!nwr[k]) begin
                    mem[address[9:2]][8*k +: 8] = wdata[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/tiny_core.sv */
`default_nettype none
`include "core_params.svh"

module tiny_core (
    input wire clk,
    input wire nreset,
    output wire core_pkg::word_t address,
    input wire core_pkg::word_t data_in,
    output wire core_pkg::word_t data_out,
    output wire nrd,
    output wire [3:0] nwr,
    input wire ready,
    output wire hlt,
    output wire error
);
    import core_pkg::*;

    wire stage_t stage;
    wire go;
    wire instr_t instr;
    wire word_t pc;
    wire [$clog2(`CORE_NREGS)-1:0] rs1;
    wire [$clog2(`CORE_NREGS)-1:0] rs2;
    wire [$clog2(`CORE_NREGS)-1:0] rd;
    wire alu_op_t alu_op;
    wire op1_pc;
    wire op2_imm;
    wire word_t imm;
    wire is_branch;
    wire is_jump;
    wire is_jalr;
    wire is_load;
    wire is_store;
    wire wb_src_t wb_src;
    wire illegal;
    wire halt_req;
    wire word_t rs1_data;
    wire word_t alu_result;
    wire take_branch;
    wire word_t next_pc;

    fetch_sequencer fetch_sequencer_inst (
        .clk(clk),
        .nreset(nreset),
        .ready(ready),
        .data_in(data_in),
        .illegal(illegal),
        .halt_req(halt_req),
        .is_load(is_load),
        .is_store(is_store),
        .take_branch(take_branch),
        .next_pc(next_pc),
        .alu_result(alu_result),
        .stage(stage),
        .go(go),
        .instr(instr),
        .pc(pc),
        .address(address),
        .nrd(nrd),
        .nwr(nwr),
        .hlt(hlt),
        .error(error)
    );

    instr_decode instr_decode_inst (
        .instr(instr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .alu_op(alu_op),
        .op1_pc(op1_pc),
        .op2_imm(op2_imm),
        .imm(imm),
        .is_branch(is_branch),
        .is_jump(is_jump),
        .is_jalr(is_jalr),
        .is_load(is_load),
        .is_store(is_store),
        .wb_src(wb_src),
        .illegal(illegal),
        .halt_req(halt_req)
    );

    alu_execute alu_execute_inst (
        .clk(clk),
        .nreset(nreset),
        .stage(stage),
        .go(go),
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(data_out), // store data doubles as operand 2
        .imm(imm),
        .alu_op(alu_op),
        .op1_pc(op1_pc),
        .op2_imm(op2_imm),
        .is_branch(is_branch),
        .is_jump(is_jump),
        .is_jalr(is_jalr),
        .funct3(instr.r.funct3),
        .alu_result(alu_result),
        .take_branch(take_branch),
        .next_pc(next_pc)
    );

    reg_writeback reg_writeback_inst (
        .clk(clk),
        .nreset(nreset),
        .stage(stage),
        .go(go),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .wb_src(wb_src),
        .alu_result(alu_result),
        .pc(pc),
        .data_in(data_in),
        .rs1_data(rs1_data),
        .rs2_data(data_out)
    );

endmodule

`default_nettype wire

/* rtl/reg_writeback.sv */
`default_nettype none
`include "core_params.svh"

module reg_writeback (
    input wire clk,
    input wire nreset,
    input wire core_pkg::stage_t stage,
    input wire go,
    input wire [$clog2(`CORE_NREGS)-1:0] rs1,
    input wire [$clog2(`CORE_NREGS)-1:0] rs2,
    input wire [$clog2(`CORE_NREGS)-1:0] rd,
    input wire core_pkg::wb_src_t wb_src,
    input wire core_pkg::word_t alu_result,
    input wire core_pkg::word_t pc,
    input wire core_pkg::word_t data_in,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data
);
    import core_pkg::*;

    word_t regs [`CORE_NREGS];
    word_t wr_data;
    logic wr_en;

    always_comb begin
        case (wb_src)
            WB_LINK: wr_data = pc + word_t'(4);
            WB_LOAD: wr_data = data_in;
            default: wr_data = alu_result;
        endcase
    end

    assign wr_en = go && stage == ST_DONE && wb_src != WB_NONE && rd != '0; // x0 never written

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int k = 0; k < `CORE_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wr_data;
        end
    end

    // operands sampled as the decode stage ends
    always_ff @(posedge clk) begin
        if (go && stage == ST_DECODE) begin
            rs1_data <= regs[rs1];
            rs2_data <= regs[rs2];
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_execute.sv */
`default_nettype none
`include "core_params.svh"

module alu_execute (
    input wire clk,
    input wire nreset,
    input wire core_pkg::stage_t stage,
    input wire go,
    input wire core_pkg::word_t pc,
    input wire core_pkg::word_t rs1_data,
    input wire core_pkg::word_t rs2_data,
    input wire core_pkg::word_t imm,
    input wire core_pkg::alu_op_t alu_op,
    input wire op1_pc,
    input wire op2_imm,
    input wire is_branch,
    input wire is_jump,
    input wire is_jalr,
    input wire [2:0] funct3,
    output core_pkg::word_t alu_result,
    output logic take_branch,
    output core_pkg::word_t next_pc
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    word_t op1;
    word_t op2;
    word_t diff;
    word_t alu_out;
    word_t target_sum;
    word_t target;
    logic borrow;
    logic less_s;
    logic cond;
    logic [SHAMT_W-1:0] shamt;

    assign op1 = op1_pc ? pc : rs1_data;
    assign op2 = op2_imm ? imm : rs2_data;

    // one subtractor serves SUB, SLT, SLTU and the branch compare
    assign {borrow, diff} = {1'b0, op1} - {1'b0, op2};
    assign less_s = (op1[`CORE_XLEN-1] != op2[`CORE_XLEN-1]) ? op1[`CORE_XLEN-1] : borrow;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (funct3)
            3'b000: cond = diff == '0;
            3'b001: cond = diff != '0;
            3'b100: cond = less_s;
            3'b101: cond = !less_s;
            3'b110: cond = borrow;
            default: cond = !borrow;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = op1 + op2;
            ALU_SUB: alu_out = diff;
            ALU_SLL: alu_out = op1 << shamt;
            ALU_SLT: alu_out = word_t'(less_s);
            ALU_SLTU: alu_out = word_t'(borrow);
            ALU_XOR: alu_out = op1 ^ op2;
            ALU_SRL: alu_out = op1 >> shamt;
            ALU_SRA: alu_out = word_t'($signed(op1) >>> shamt);
            ALU_OR: alu_out = op1 | op2;
            ALU_AND: alu_out = op1 & op2;
            default: alu_out = op2;
        endcase
    end

    assign target_sum = (is_jalr ? rs1_data : pc) + imm;
    assign target = is_jalr ? {target_sum[`CORE_XLEN-1:1], 1'b0} : target_sum;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            take_branch <= 1'b0;
        end else if (go && stage == ST_EXEC) begin
            take_branch <= is_jump || (is_branch && cond);
        end
    end

    always_ff @(posedge clk) begin
        if (go && stage == ST_EXEC) begin
            alu_result <= alu_out; // also the load/store address
            next_pc <= target;
        end
    end

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`default_nettype none
`include "core_params.svh"

module instr_decode (
    input wire core_pkg::instr_t instr,
    output logic [$clog2(`CORE_NREGS)-1:0] rs1,
    output logic [$clog2(`CORE_NREGS)-1:0] rs2,
    output logic [$clog2(`CORE_NREGS)-1:0] rd,
    output core_pkg::alu_op_t alu_op,
    output logic op1_pc,
    output logic op2_imm,
    output core_pkg::word_t imm,
    output logic is_branch,
    output logic is_jump,
    output logic is_jalr,
    output logic is_load,
    output logic is_store,
    output core_pkg::wb_src_t wb_src,
    output logic illegal,
    output logic halt_req
);
    import core_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic [6:0] funct7;
    logic [2:0] funct3;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd = instr.r.rd;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    assign imm_i = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(`CORE_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{(`CORE_XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'h000};
    assign imm_j = {{(`CORE_XLEN-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

    always_comb begin
        alu_op = ALU_ADD;
        op1_pc = 1'b0;
        op2_imm = 1'b1;
        imm = imm_i;
        is_branch = 1'b0;
        is_jump = 1'b0;
        is_jalr = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        wb_src = WB_NONE;
        illegal = 1'b0;
        halt_req = 1'b0;
        case (opcode_t'(instr.r.opcode))
            OPC_LUI: begin
                alu_op = ALU_PASS2;
                imm = imm_u;
                wb_src = WB_ALU;
            end
            OPC_AUIPC: begin
                op1_pc = 1'b1;
                imm = imm_u;
                wb_src = WB_ALU;
            end
            OPC_JAL: begin
                is_jump = 1'b1;
                imm = imm_j;
                wb_src = WB_LINK;
            end
            OPC_JALR: begin
                is_jump = 1'b1;
                is_jalr = 1'b1;
                wb_src = WB_LINK;
                illegal = funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                op2_imm = 1'b0; // compare against rs2
                imm = imm_b;
                illegal = funct3[2:1] == 2'b01;
            end
            OPC_LOAD: begin
                is_load = 1'b1;
                wb_src = WB_LOAD;
                illegal = funct3 != 3'b010; // LW only
            end
            OPC_STORE: begin
                is_store = 1'b1;
                imm = imm_s;
                illegal = funct3 != 3'b010;
            end
            OPC_OP_IMM: begin
                alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                wb_src = WB_ALU;
                illegal = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                          (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000);
            end
            OPC_OP: begin
                op2_imm = 1'b0;
                alu_op = arith_op(funct3, funct7[5]);
                wb_src = WB_ALU;
                illegal = !(funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_SYSTEM: begin
                halt_req = instr.raw == 32'h0010_0073; // EBREAK
                illegal = !halt_req;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
        if (illegal) begin
            wb_src = WB_NONE;
            is_branch = 1'b0;
            is_jump = 1'b0;
            is_load = 1'b0;
            is_store = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_sequencer.sv */
`default_nettype none
`include "core_params.svh"

module fetch_sequencer (
    input wire clk,
    input wire nreset,
    input wire ready,
    input wire core_pkg::word_t data_in,
    input wire illegal,
    input wire halt_req,
    input wire is_load,
    input wire is_store,
    input wire take_branch,
    input wire core_pkg::word_t next_pc,
    input wire core_pkg::word_t alu_result,
    output core_pkg::stage_t stage,
    output logic go,
    output core_pkg::instr_t instr,
    output core_pkg::word_t pc,
    output core_pkg::word_t address,
    output logic nrd,
    output logic [3:0] nwr,
    output logic hlt,
    output logic error
);
    import core_pkg::*;

    instr_t instr_q;
    logic last_stage;
    logic mem_access;
    logic mem_misaligned;
    logic target_misaligned;
    logic fault;
    logic stop;

    assign go = ready && !hlt;
    assign last_stage = stage == stage_t'(`CORE_NSTAGES - 1);

    assign mem_access = is_load || is_store;
    assign mem_misaligned = mem_access && alu_result[1:0] != 2'b00;
    assign target_misaligned = take_branch && next_pc[1:0] != 2'b00; // caught before the fetch
    assign fault = illegal || mem_misaligned || target_misaligned;
    assign stop = halt_req || fault;

    // bus word forwarded while decoding so the register read sees its fields
    assign instr = (stage == ST_DECODE) ? instr_t'(data_in) : instr_q;

    assign address = (last_stage && mem_access) ? alu_result : pc;

    // strobes follow the stage only, so a stall holds them
    assign nrd = !(!hlt && (stage == ST_FETCH || stage == ST_DECODE ||
                            (last_stage && is_load && !fault)));
    assign nwr = (!hlt && last_stage && is_store && !fault) ? 4'b0000 : 4'b1111;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            stage <= ST_FETCH;
            pc <= `CORE_RESET_PC;
            hlt <= 1'b0;
            error <= 1'b0;
        end else if (go) begin
            if (last_stage) begin
                stage <= ST_FETCH;
                hlt <= stop;
                error <= fault;
                if (!stop) begin
                    pc <= take_branch ? next_pc : pc + word_t'(4);
                end
            end else begin
                stage <= stage_t'(stage + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go && stage == ST_DECODE) begin
            instr_q <= instr;
        end
    end

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none
`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2 // second operand straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LINK,
        WB_LOAD
    } wb_src_t;

    typedef enum logic [$clog2(`CORE_NSTAGES)-1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_DONE
    } stage_t;

endpackage

`default_nettype wire

/* rtl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

`define CORE_NREGS 32

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

`define CORE_NSTAGES 4

`endif
